// ==== common/AdcAcqPkg.sv ====
// Shared definitions for the calorimeter ADC acquisition path
package AdcAcqPkg;

    ////////////////////////////////////////////////////////////////////
    // Converter and output word widths
    ////////////////////////////////////////////////////////////////////

    // AD9220 class converter code width
    localparam int AdcWidth = 12;

    // Width of one word passed upward
    localparam int WordWidth = 16;

    // Unused high bits of the output word
    localparam int PadWidth = WordWidth - AdcWidth - 1;

    // Output word, zero padding on top, then out-of-range, then code
    typedef struct packed {
        logic [PadWidth-1:0] Zero;
        logic                Otr;
        logic [AdcWidth-1:0] Code;
    } AdcWord_t;

    ////////////////////////////////////////////////////////////////////
    // Converter pipeline
    ////////////////////////////////////////////////////////////////////

    // Conversions in flight inside the converter
    // First samples after the clock starts are stale
    localparam int PipeDiscard = 3;

    // Counter width that can reach PipeDiscard
    localparam int DiscardWidth = $clog2(PipeDiscard + 1);

endpackage

// ==== adcControl/Ad9220Interface.sv ====
`timescale 1ns/1ps

module Ad9220Interface
    import AdcAcqPkg::*;
#(
    // Clk cycles per ADC clock period, even, at least 4
    parameter int AdcClkDiv = 10
) (
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                AdcStart,
    input  logic [AdcWidth-1:0] AdcCode,
    input  logic                AdcOtr,
    output logic                AdcClk,
    output logic [AdcWidth-1:0] SampleCode,
    output logic                SampleOtr,
    output logic                SampleValid
);

    ////////////////////////////////////////////////////////////////////
    // Phase counter constants
    ////////////////////////////////////////////////////////////////////

    localparam int HalfDiv    = AdcClkDiv / 2;
    localparam int PhaseWidth = $clog2(AdcClkDiv);

    // Last Clk cycle of the high phase
    localparam logic [PhaseWidth-1:0] FallPhase = PhaseWidth'(HalfDiv - 1);
    // Pins are registered going into the last cycle of a period
    localparam logic [PhaseWidth-1:0] CapPhase  = PhaseWidth'(AdcClkDiv - 2);
    // Last Clk cycle of the low phase
    localparam logic [PhaseWidth-1:0] LastPhase = PhaseWidth'(AdcClkDiv - 1);

    // Divider only makes sense for even ratios of 4 or more
    if ((AdcClkDiv < 4) || (AdcClkDiv % 2 != 0)) begin : gBadDiv
        $error("AdcClkDiv must be even and at least 4");
    end

    logic                  Running;
    logic [PhaseWidth-1:0] PhaseCnt;
    logic                  CaptureNow;

    ////////////////////////////////////////////////////////////////////
    // ADC clock generation
    ////////////////////////////////////////////////////////////////////

    // Period starts with the high phase at PhaseCnt 0
    // Stop is only taken at the period end, so the low phase is never cut
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            Running  <= 1'b0;
            PhaseCnt <= '0;
            AdcClk   <= 1'b0;
        end else if (!Running) begin
            // First rising edge one cycle after start
            if (AdcStart) begin
                Running  <= 1'b1;
                PhaseCnt <= '0;
                AdcClk   <= 1'b1;
            end
        end else if (PhaseCnt == LastPhase) begin
            PhaseCnt <= '0;
            if (AdcStart) begin
                AdcClk <= 1'b1;
            end else begin
                // Leave the clock parked low
                Running <= 1'b0;
            end
        end else begin
            PhaseCnt <= PhaseCnt + 1'b1;
            if (PhaseCnt == FallPhase) begin
                AdcClk <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Sample capture
    ////////////////////////////////////////////////////////////////////

    // One Clk before the rising edge, pins hold the previous conversion
    assign CaptureNow = Running && AdcStart && (PhaseCnt == CapPhase);

    // Code and flag taken on the same edge from one conversion
    always_ff @(posedge Clk) begin
        if (CaptureNow) begin
            SampleCode <= AdcCode;
            SampleOtr  <= AdcOtr;
        end
    end

    // Strobe in the cycle the captured sample is visible
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            SampleValid <= 1'b0;
        end else begin
            SampleValid <= CaptureNow;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    // Parked divider never strobes
    aNoStrobeStopped: assert property (@(posedge Clk) disable iff (!reset_n)
        !Running |-> !SampleValid)
        else $error("SampleValid while ADC clock is stopped");

    // One strobe per ADC period
    aSingleStrobe: assert property (@(posedge Clk) disable iff (!reset_n)
        SampleValid |=> !SampleValid)
        else $error("SampleValid high in two consecutive cycles");

endmodule

// ==== adcControl/AdcControl.sv ====
`timescale 1ns/1ps

module AdcControl
    import AdcAcqPkg::*;
(
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                Hold,
    input  logic                StartAcq,
    input  logic [3:0]          AdcStartDelay,
    input  logic [7:0]          AdcDataNumber,
    input  logic [AdcWidth-1:0] SampleCode,
    input  logic                SampleOtr,
    input  logic                SampleValid,
    output logic                AdcStart,
    output AdcWord_t            Data,
    output logic                DataValid,
    output logic                AcqDone
);

    typedef enum logic [2:0] {
        Idle,
        StartDelay,
        Discard,
        Acquire,
        Done
    } AcqState_t;

    AcqState_t State;

    // Hold synchronizer and edge history
    logic HoldMeta;
    logic HoldSync;
    logic HoldSyncD;
    logic HoldRise;

    // Counters, all on Clk
    logic [3:0]              DelayCnt;
    logic [DiscardWidth-1:0] DiscardCnt;
    logic [7:0]              WordCnt;

    // End of run, word budget spent or Hold gone
    logic AcqEnd;

    ////////////////////////////////////////////////////////////////////
    // Hold synchronizer
    ////////////////////////////////////////////////////////////////////

    // Two flops for the asynchronous Hold, a third for the edge
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            HoldMeta  <= 1'b0;
            HoldSync  <= 1'b0;
            HoldSyncD <= 1'b0;
        end else begin
            HoldMeta  <= Hold;
            HoldSync  <= HoldMeta;
            HoldSyncD <= HoldSync;
        end
    end

    assign HoldRise = HoldSync && !HoldSyncD;

    ////////////////////////////////////////////////////////////////////
    // End condition and output strobe
    ////////////////////////////////////////////////////////////////////

    // Zero words requested ends the run right away
    assign AcqEnd = (WordCnt == AdcDataNumber) || !HoldSync;

    // No strobe once the end is seen
    assign DataValid = (State == Acquire) && SampleValid && !AcqEnd;

    // One cycle in Done
    assign AcqDone = (State == Done);

    // Word layout from the package type
    always_comb begin
        Data      = '0;
        Data.Otr  = SampleOtr;
        Data.Code = SampleCode;
    end

    ////////////////////////////////////////////////////////////////////
    // Acquisition FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            State      <= Idle;
            AdcStart   <= 1'b0;
            DelayCnt   <= '0;
            DiscardCnt <= '0;
            WordCnt    <= '0;
        end else begin
            case (State)
                Idle: begin
                    DelayCnt   <= '0;
                    DiscardCnt <= '0;
                    WordCnt    <= '0;
                    // Only an armed Hold edge starts a run
                    if (StartAcq && HoldRise) begin
                        State <= StartDelay;
                    end
                end

                StartDelay: begin
                    // Count 0..AdcStartDelay, then start the converter
                    if (DelayCnt < AdcStartDelay) begin
                        DelayCnt <= DelayCnt + 1'b1;
                    end else begin
                        State    <= Discard;
                        AdcStart <= 1'b1;
                    end
                end

                Discard: begin
                    if (AcqEnd) begin
                        State    <= Done;
                        AdcStart <= 1'b0;
                    end else if (SampleValid) begin
                        // Drop samples still inside the converter pipeline
                        if (DiscardCnt == DiscardWidth'(PipeDiscard - 1)) begin
                            State <= Acquire;
                        end
                        DiscardCnt <= DiscardCnt + 1'b1;
                    end
                end

                Acquire: begin
                    if (AcqEnd) begin
                        State    <= Done;
                        AdcStart <= 1'b0;
                    end else if (DataValid) begin
                        WordCnt <= WordCnt + 1'b1;
                    end
                end

                Done: begin
                    State <= Idle;
                end

                default: begin
                    State    <= Idle;
                    AdcStart <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    // Words only while acquiring with the converter running
    aDataInAcq: assert property (@(posedge Clk) disable iff (!reset_n)
        DataValid |-> (State == Acquire) && AdcStart)
        else $error("DataValid outside the acquire state");

    // Converter held stopped whenever the FSM rests
    aIdleStopped: assert property (@(posedge Clk) disable iff (!reset_n)
        (State == Idle) |-> !AdcStart)
        else $error("AdcStart high in idle");

    // Never more words than requested
    aWordLimit: assert property (@(posedge Clk) disable iff (!reset_n)
        (State != Idle) |-> (WordCnt <= AdcDataNumber))
        else $error("Word count above AdcDataNumber");

endmodule

// ==== verilog/AdcAcqTop.sv ====
`timescale 1ns/1ps

module AdcAcqTop
    import AdcAcqPkg::*;
#(
    // Clk cycles per ADC clock period
    parameter int AdcClkDiv = 10
) (
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                Hold,
    input  logic                StartAcq,
    input  logic [3:0]          AdcStartDelay,
    input  logic [7:0]          AdcDataNumber,
    input  logic [AdcWidth-1:0] AdcCode,
    input  logic                AdcOtr,
    output logic                AdcClk,
    output AdcWord_t            Data,
    output logic                DataValid,
    output logic                AcqDone
);

    // Controller to converter interface
    logic                AdcStart;
    logic [AdcWidth-1:0] SampleCode;
    logic                SampleOtr;
    logic                SampleValid;

    ////////////////////////////////////////////////////////////////////
    // Acquisition controller
    ////////////////////////////////////////////////////////////////////

    AdcControl uAdcControl (
        .Clk           (Clk),
        .reset_n       (reset_n),
        .Hold          (Hold),
        .StartAcq      (StartAcq),
        .AdcStartDelay (AdcStartDelay),
        .AdcDataNumber (AdcDataNumber),
        .SampleCode    (SampleCode),
        .SampleOtr     (SampleOtr),
        .SampleValid   (SampleValid),
        .AdcStart      (AdcStart),
        .Data          (Data),
        .DataValid     (DataValid),
        .AcqDone       (AcqDone)
    );

    ////////////////////////////////////////////////////////////////////
    // Converter pin interface
    ////////////////////////////////////////////////////////////////////

    // Divider ratio handed down from here
    Ad9220Interface #(
        .AdcClkDiv (AdcClkDiv)
    ) uAd9220Interface (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .AdcStart    (AdcStart),
        .AdcCode     (AdcCode),
        .AdcOtr      (AdcOtr),
        .AdcClk      (AdcClk),
        .SampleCode  (SampleCode),
        .SampleOtr   (SampleOtr),
        .SampleValid (SampleValid)
    );

endmodule

// ==== dv/ClockGen.sv ====
`timescale 1ns/1ps

module ClockGen #(
    // Half of the 8 ns period
    parameter int HalfPeriod  = 4,
    parameter int ResetCycles = 4
) (
    output logic Clk,
    output logic reset_n
);

    // Free running clock
    initial begin
        Clk = 1'b0;
        forever #(HalfPeriod) Clk = ~Clk;
    end

    // Reset low for the first cycles, released just after an edge
    initial begin
        reset_n = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

// ==== dv/Ad9220Model.sv ====
`timescale 1ns/1ps

module Ad9220Model
    import AdcAcqPkg::*;
(
    input  logic                AdcClk,
    input  logic                Rearm,
    input  int                  Base,
    output logic [AdcWidth-1:0] AdcCode,
    output logic                AdcOtr
);

    localparam int MaxCode = (1 << AdcWidth) - 1;

    // Conversions in flight, flag on top of the code
    logic [AdcWidth:0] Pipe [PipeDiscard];
    int                ConvCnt;

    // Input clipped at full scale with the out-of-range flag
    function automatic logic [AdcWidth:0] convert(input int Value);
        if (Value > MaxCode) begin
            return {1'b1, AdcWidth'(MaxCode)};
        end
        return {1'b0, AdcWidth'(Value)};
    endfunction

    // Stale stage content, flag set with a code below full scale
    function automatic logic [AdcWidth:0] garbage(input int Stage);
        return {1'b1, AdcWidth'(12'hBAD ^ Stage)};
    endfunction

    // Conversion k sampled on edge k, reaches the pins on edge k+3
    always @(posedge AdcClk or posedge Rearm) begin
        if (Rearm) begin
            ConvCnt <= 0;
            for (int k = 0; k < PipeDiscard; k++) begin
                Pipe[k] <= garbage(k);
            end
            {AdcOtr, AdcCode} <= garbage(PipeDiscard);
        end else begin
            // Ramp input, one step per conversion
            Pipe[0] <= convert(Base + ConvCnt);
            for (int k = 1; k < PipeDiscard; k++) begin
                Pipe[k] <= Pipe[k-1];
            end
            {AdcOtr, AdcCode} <= Pipe[PipeDiscard-1];
            ConvCnt <= ConvCnt + 1;
        end
    end

endmodule

// ==== dv/AdcAcqTb.sv ====
`timescale 1ns/1ps

module AdcAcqTb
    import AdcAcqPkg::*;
();

    localparam int DoneTimeout  = 1000;
    localparam int SettleCycles = 40;
    localparam int MaxCode      = (1 << AdcWidth) - 1;
    // Falling edges from Hold rise to first AdcClk high, on top of the delay
    // Two sync flops, edge detect, one extra delay cycle, divider start, sample
    localparam int StartLatency = 6;

    logic                Clk;
    logic                reset_n;
    logic                Hold;
    logic                StartAcq;
    logic [3:0]          AdcStartDelay;
    logic [7:0]          AdcDataNumber;
    logic [AdcWidth-1:0] AdcCode;
    logic                AdcOtr;
    logic                AdcClk;
    AdcWord_t            Data;
    logic                DataValid;
    logic                AcqDone;
    logic                Rearm;
    int                  RampBase;

    // Test table with one entry per row in each queue
    string tName[$];
    int    tStart[$];
    int    tDelay[$];
    int    tNumber[$];
    int    tBase[$];
    int    tHoldLen[$];
    int    tExpWords[$];
    int    tDip[$];

    // Run bookkeeping
    int errCount;
    int testErrs;
    int failedTests;
    int wordCnt;
    int doneCnt;
    logic holdBusy;

    ClockGen uClockGen (
        .Clk     (Clk),
        .reset_n (reset_n)
    );

    AdcAcqTop #(
        .AdcClkDiv (10)
    ) dut (
        .Clk           (Clk),
        .reset_n       (reset_n),
        .Hold          (Hold),
        .StartAcq      (StartAcq),
        .AdcStartDelay (AdcStartDelay),
        .AdcDataNumber (AdcDataNumber),
        .AdcCode       (AdcCode),
        .AdcOtr        (AdcOtr),
        .AdcClk        (AdcClk),
        .Data          (Data),
        .DataValid     (DataValid),
        .AcqDone       (AcqDone)
    );

    // Converter on the board with the ramp base chosen per test
    Ad9220Model uAdcModel (
        .AdcClk  (AdcClk),
        .Rearm   (Rearm),
        .Base    (RampBase),
        .AdcCode (AdcCode),
        .AdcOtr  (AdcOtr)
    );

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    // Inputs move 1 ns after the rising edge
    task automatic stepClk(input int n);
        repeat (n) @(posedge Clk);
        #1;
    endtask

    task automatic noteError();
        errCount++;
        testErrs++;
    endtask

    // Word i of a run is base+i, or full scale with the flag past the top
    function automatic logic [WordWidth-1:0] rampWord(input int Base, input int Index);
        int                   v;
        logic [WordWidth-1:0] w;
        v = Base + Index;
        w = '0;
        if (v > MaxCode) begin
            w[AdcWidth]       = 1'b1;
            w[AdcWidth-1:0]   = AdcWidth'(MaxCode);
        end else begin
            w[AdcWidth-1:0]   = AdcWidth'(v);
        end
        return w;
    endfunction

    task automatic addRow(input string name, input int start, input int delay,
                          input int number, input int base, input int holdLen,
                          input int expWords, input int dip);
        tName.push_back(name);
        tStart.push_back(start);
        tDelay.push_back(delay);
        tNumber.push_back(number);
        tBase.push_back(base);
        tHoldLen.push_back(holdLen);
        tExpWords.push_back(expWords);
        tDip.push_back(dip);
    endtask

    // name, StartAcq, delay, words, base, Hold cycles, expected words, dip
    // Expected -1 marks an early end with 1 up to words-1 allowed
    task automatic loadTable();
        addRow("full_ramp", 1, 2, 12, 100, 600, 12, 0);
        addRow("otr_clip", 1, 5, 10, 4090, 600, 10, 0);
        addRow("otr_top_code", 1, 0, 4, 4095, 600, 4, 0);
        addRow("early_end", 1, 3, 40, 500, 150, -1, 0);
        addRow("gated_start", 0, 2, 8, 300, 60, 0, 0);
        addRow("zero_words", 1, 2, 0, 200, 300, 0, 0);
        for (int k = 0; k < 4; k++) begin
            addRow($sformatf("rand_delay_%0d", k), 1, int'($urandom % 16),
                   6 + 3 * k, 1000 + 250 * k, 600, 6 + 3 * k, 0);
        end
        // Hold dips and rises again while the start delay runs
        addRow("second_edge", 1, 15, 8, 2000, 600, 8, 1);
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while ((reset_n !== 1'b1) && (cycles < 50)) begin
            @(posedge Clk);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            $display("Reset was never released");
            errCount++;
        end
        stepClk(2);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Hold driver and output monitor
    ////////////////////////////////////////////////////////////////////

    task automatic driveHold(input int holdLen, input int dip);
        Hold = 1'b1;
        if (dip != 0) begin
            stepClk(3);
            Hold = 1'b0;
            stepClk(2);
            Hold = 1'b1;
            stepClk(holdLen - 5);
        end else begin
            stepClk(holdLen);
        end
        Hold = 1'b0;
        holdBusy = 1'b0;
    endtask

    // Mid-cycle sampling until AcqDone and the Hold pulse are over
    task automatic collectRun(input int idx);
        int                   cycles;
        int                   firstClk;
        int                   expFirst;
        logic [WordWidth-1:0] expWord;
        cycles   = 0;
        firstClk = -1;
        expFirst = tDelay[idx] + StartLatency;
        while (((doneCnt == 0) || holdBusy) && (cycles < DoneTimeout)) begin
            @(negedge Clk);
            cycles++;
            // First converter clock edge of the run
            if ((firstClk < 0) && (AdcClk === 1'b1)) begin
                firstClk = cycles;
            end
            if (DataValid && (doneCnt != 0)) begin
                $display("Test %s: DataValid after AcqDone", tName[idx]);
                noteError();
            end else if (DataValid) begin
                expWord = rampWord(tBase[idx], wordCnt);
                if (Data !== expWord) begin
                    $display("FAILED %s word %0d expected %h actual %h",
                             tName[idx], wordCnt, expWord, Data);
                    noteError();
                end
                wordCnt++;
            end
            if (AcqDone) begin
                doneCnt++;
            end
        end
        if ((doneCnt == 0) && (tStart[idx] != 0)) begin
            $display("Test %s timed out after %0d cycles waiting for AcqDone",
                     tName[idx], DoneTimeout);
            noteError();
        end
        if ((tStart[idx] != 0) && (firstClk != expFirst)) begin
            $display("FAILED %s AdcClk start cycle expected %0d actual %0d",
                     tName[idx], expFirst, firstClk);
            noteError();
        end
    endtask

    // Quiet gap with the converter clock parked low once the high phase ends
    task automatic settleCheck(input int idx);
        for (int c = 0; c < SettleCycles; c++) begin
            @(negedge Clk);
            if (DataValid || AcqDone) begin
                $display("Test %s: strobe seen between acquisitions", tName[idx]);
                noteError();
            end
            if ((c >= SettleCycles / 2) && (AdcClk !== 1'b0)) begin
                $display("Test %s: AdcClk running between acquisitions", tName[idx]);
                noteError();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // One table row
    ////////////////////////////////////////////////////////////////////

    task automatic runTest(input int idx);
        testErrs = 0;
        wordCnt  = 0;
        doneCnt  = 0;
        StartAcq      = (tStart[idx] != 0);
        AdcStartDelay = 4'(tDelay[idx]);
        AdcDataNumber = 8'(tNumber[idx]);
        RampBase      = tBase[idx];
        // Fresh pipeline, stale content until it fills
        Rearm = 1'b1;
        stepClk(1);
        Rearm = 1'b0;
        stepClk(2);
        holdBusy = 1'b1;
        fork
            driveHold(tHoldLen[idx], tDip[idx]);
            collectRun(idx);
        join
        if ((tStart[idx] == 0) && (doneCnt != 0)) begin
            $display("Test %s: AcqDone pulsed with StartAcq low", tName[idx]);
            noteError();
        end
        if (doneCnt > 1) begin
            $display("Test %s: AcqDone pulsed %0d times", tName[idx], doneCnt);
            noteError();
        end
        if ((tExpWords[idx] >= 0) && (wordCnt != tExpWords[idx])) begin
            $display("FAILED %s word count expected %0d actual %0d",
                     tName[idx], tExpWords[idx], wordCnt);
            noteError();
        end
        if ((tExpWords[idx] < 0) && ((wordCnt < 1) || (wordCnt >= tNumber[idx]))) begin
            $display("FAILED %s word count expected 1 to %0d actual %0d",
                     tName[idx], tNumber[idx] - 1, wordCnt);
            noteError();
        end
        settleCheck(idx);
        if (testErrs != 0) begin
            failedTests++;
        end
        $display("Test %s %s: words %0d, delay %0d, errors %0d", tName[idx],
                 (testErrs == 0) ? "ok" : "failed", wordCnt, tDelay[idx], testErrs);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        Hold          = 1'b0;
        StartAcq      = 1'b0;
        AdcStartDelay = '0;
        AdcDataNumber = '0;
        Rearm         = 1'b0;
        RampBase      = 0;
        holdBusy      = 1'b0;
        errCount      = 0;
        failedTests   = 0;
        void'($urandom(32'hd05654c6));
        loadTable();
        #1;
        Rearm = 1'b1;
        waitReset();
        Rearm = 1'b0;
        if (errCount == 0) begin
            for (int i = 0; i < tName.size(); i++) begin
                runTest(i);
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tName.size(),
                 tName.size() - failedTests, failedTests, errCount);
        if (errCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/AdcAcqPkg.sv
adcControl/Ad9220Interface.sv
adcControl/AdcControl.sv
verilog/AdcAcqTop.sv
dv/ClockGen.sv
dv/Ad9220Model.sv
dv/AdcAcqTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := AdcAcqTb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
LINTFLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Pass only when the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
